//--- filelist.f
hw/dcache_pkg.sv
hw/memop_pkg.sv
hw/dcache_req_decode.sv
hw/dcache_tags.sv
hw/dcache_data.sv
hw/dcache_ctrl.sv
hw/dcache_load_align.sv
hw/dcache_top.sv
tb/dcache_mem_model.sv
tb/dcache_tb.sv

//--- hw/dcache_ctrl.sv
`timescale 1ns/100ps

module dcache_ctrl
    import dcache_pkg::*;
    import memop_pkg::*;
(
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            head_valid_i,
    input  dcache_req_t     head_i,
    input  cache_index_t    index_i,
    input  logic            hit_i,
    input  logic            mem_line_valid_i,
    output logic            pop_o,
    output logic            rd_o,
    output logic            wr_o,
    output logic            fill_o,
    output logic            mem_refill_valid_o,
    output mem_refill_req_t mem_refill_o,
    output logic            mem_wt_valid_o,
    output mem_wt_t         mem_wt_o,
    output logic            ld_valid_o
);

typedef enum logic [1:0] {
    LOOKUP,
    REFILL_REQ,
    REFILL_WAIT
} ctrl_state_e;

ctrl_state_e state_q;
ctrl_state_e state_d;
logic        store_now;

assign store_now = (state_q == LOOKUP) && head_valid_i && head_i.is_store;

always_comb begin
    state_d = state_q;
    pop_o   = 1'b0;
    rd_o    = 1'b0;
    wr_o    = 1'b0;
    fill_o  = 1'b0;
    unique case (state_q)
        LOOKUP: begin
            if (head_valid_i) begin
                if (head_i.is_store) begin
                    pop_o = 1'b1;
                    wr_o  = hit_i;  // no write allocate
                end else if (hit_i) begin
                    pop_o = 1'b1;
                    rd_o  = 1'b1;
                end else begin
                    state_d = REFILL_REQ;
                end
            end
        end
        REFILL_REQ:  state_d = REFILL_WAIT;
        REFILL_WAIT: begin
            if (mem_line_valid_i) begin
                fill_o  = 1'b1;
                state_d = LOOKUP;  // replay the same load, it hits now
            end
        end
        default: state_d = LOOKUP;
    endcase
end

assign ld_valid_o         = rd_o;
assign mem_refill_valid_o = (state_q == REFILL_REQ);
assign mem_refill_o       = '{line_addr: {head_i.addr[WORD_SIZE-1 -: DCACHE_TAG_SIZE], index_i}};

always_ff @(posedge clk_i) begin
    if (rst_i) begin
        state_q        <= LOOKUP;
        mem_wt_valid_o <= 1'b0;
    end else begin
        state_q        <= state_d;
        mem_wt_valid_o <= store_now;
    end
end

// write-through payload, every store hit or miss
always_ff @(posedge clk_i) begin
    if (store_now) mem_wt_o <= '{addr: head_i.addr, data: head_i.wdata, size: head_i.size};
end

line_only_when_waiting: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_line_valid_i |-> state_q == REFILL_WAIT);

endmodule : dcache_ctrl

//--- hw/dcache_data.sv
`timescale 1ns/100ps

module dcache_data
    import dcache_pkg::*;
    import memop_pkg::*;
(
    input  logic          clk_i,
    input  logic          rd_i,
    input  logic          wr_i,
    input  logic          fill_i,
    input  cache_index_t  index_i,
    input  cache_offset_t offset_i,
    input  memop_size_e   size_i,
    input  word_t         wdata_i,
    input  line_t         line_i,
    output word_t         rdata_o
);

logic [DCACHE_NUM_LINES-1:0][DCACHE_LINE_BYTES-1:0][7:0] lines;

// byte positions above the offset, accesses never cross a line
cache_offset_t off1;
cache_offset_t off2;
cache_offset_t off3;

assign off1 = offset_i + cache_offset_t'(1);
assign off2 = offset_i + cache_offset_t'(2);
assign off3 = offset_i + cache_offset_t'(3);

always_comb begin
    rdata_o = '0;
    if (rd_i) begin
        unique case (size_i)
            BYTE: rdata_o = {{(WORD_SIZE-8){1'b0}}, lines[index_i][offset_i]};
            HALF: rdata_o = {{(WORD_SIZE-16){1'b0}}, lines[index_i][off1],
                             lines[index_i][offset_i]};
            WORD: rdata_o = {lines[index_i][off3], lines[index_i][off2],
                             lines[index_i][off1], lines[index_i][offset_i]};
            default: ;
        endcase
    end
end

always_ff @(posedge clk_i) begin
    if (fill_i) begin
        lines[index_i] <= line_i;  // whole line from memory
    end else if (wr_i) begin
        lines[index_i][offset_i] <= wdata_i[7:0];
        if (size_i != BYTE) lines[index_i][off1] <= wdata_i[15:8];
        if (size_i == WORD) begin
            lines[index_i][off2] <= wdata_i[23:16];
            lines[index_i][off3] <= wdata_i[31:24];
        end
    end
end

// store hits and refills come from different controller states
wr_fill_exclusive: assert property (@(posedge clk_i) !(wr_i && fill_i));

endmodule : dcache_data

//--- hw/dcache_load_align.sv
`timescale 1ns/100ps

module dcache_load_align
    import dcache_pkg::*;
    import memop_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        ld_valid_i,
    input  word_t       raw_i,
    input  memop_size_e size_i,
    input  logic        unsigned_i,
    output logic        rsp_valid_o,
    output dcache_rsp_t rsp_o
);

word_t ext;

// raw word is already shifted down to bit 0
always_comb begin
    unique case (size_i)
        BYTE:    ext = {{(WORD_SIZE-8){!unsigned_i && raw_i[7]}}, raw_i[7:0]};
        HALF:    ext = {{(WORD_SIZE-16){!unsigned_i && raw_i[15]}}, raw_i[15:0]};
        default: ext = raw_i;
    endcase
end

always_ff @(posedge clk_i) begin
    if (rst_i) rsp_valid_o <= 1'b0;
    else       rsp_valid_o <= ld_valid_i;
end

always_ff @(posedge clk_i) begin
    if (ld_valid_i) rsp_o <= '{data: ext};
end

endmodule : dcache_load_align

//--- hw/dcache_pkg.sv
package dcache_pkg;

// ==================================================
// geometry
// ==================================================

localparam int WORD_SIZE = 32;

localparam int DCACHE_LINE_BYTES = 16;
localparam int DCACHE_NUM_LINES  = 16;

// address split: tag | index | offset
localparam int DCACHE_BYTE_SIZE  = 4;   // offset field
localparam int DCACHE_INDEX_SIZE = 4;
localparam int DCACHE_TAG_SIZE   = 24;

localparam int DCACHE_CREDITS = 2;      // also the request queue depth

// ==================================================
// types
// ==================================================

typedef logic [WORD_SIZE-1:0] word_t;
typedef logic [WORD_SIZE-1:0] addr_t;

typedef logic [DCACHE_LINE_BYTES*8-1:0] line_t;  // byte 0 in the low bits

typedef logic [DCACHE_INDEX_SIZE-1:0] cache_index_t;
typedef logic [DCACHE_BYTE_SIZE-1:0]  cache_offset_t;
typedef logic [DCACHE_TAG_SIZE-1:0]   cache_tag_t;

endpackage : dcache_pkg

//--- hw/dcache_req_decode.sv
`timescale 1ns/100ps

module dcache_req_decode
    import dcache_pkg::*;
    import memop_pkg::*;
(
    input  logic          clk_i,
    input  logic          rst_i,
    input  logic          req_valid_i,
    input  dcache_req_t   req_i,
    input  logic          pop_i,
    output logic          head_valid_o,
    output dcache_req_t   head_o,
    output cache_tag_t    tag_o,
    output cache_index_t  index_o,
    output cache_offset_t offset_o,
    output logic          credit_o
);

localparam int PTR_W   = $clog2(DCACHE_CREDITS);
localparam int COUNT_W = $clog2(DCACHE_CREDITS + 1);

dcache_req_t entries [DCACHE_CREDITS];

logic [PTR_W-1:0]   wr_ptr;
logic [PTR_W-1:0]   rd_ptr;
logic [COUNT_W-1:0] count;
logic               pop;

assign pop = pop_i && head_valid_o;

always_ff @(posedge clk_i) begin
    if (rst_i) begin
        wr_ptr   <= '0;
        rd_ptr   <= '0;
        count    <= '0;
        credit_o <= 1'b0;
    end else begin
        credit_o <= pop;  // one credit back per dequeued request
        if (req_valid_i) wr_ptr <= wr_ptr + 1'b1;
        if (pop)         rd_ptr <= rd_ptr + 1'b1;
        unique case ({req_valid_i, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;
        endcase
    end
end

always_ff @(posedge clk_i) begin
    if (req_valid_i) entries[wr_ptr] <= req_i;
end

assign head_valid_o = (count != '0);
assign head_o       = entries[rd_ptr];

// ==================================================
// address split
// ==================================================

assign tag_o    = head_o.addr[WORD_SIZE-1 -: DCACHE_TAG_SIZE];
assign index_o  = head_o.addr[DCACHE_BYTE_SIZE +: DCACHE_INDEX_SIZE];
assign offset_o = head_o.addr[DCACHE_BYTE_SIZE-1:0];

// core must hold a credit for every request
no_push_when_full: assert property (@(posedge clk_i) disable iff (rst_i)
    req_valid_i |-> count < DCACHE_CREDITS);

head_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
    head_valid_o |-> (head_o.size == BYTE)
                  || (head_o.size == HALF && !head_o.addr[0])
                  || (head_o.size == WORD && head_o.addr[1:0] == 2'b00));

endmodule : dcache_req_decode

//--- hw/dcache_tags.sv
`timescale 1ns/100ps

module dcache_tags
    import dcache_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_i,
    input  cache_index_t index_i,
    input  cache_tag_t   tag_i,
    input  logic         fill_i,
    output logic         hit_o
);

logic [DCACHE_NUM_LINES-1:0] valid;
cache_tag_t                  tags [DCACHE_NUM_LINES];

// valid bits
always_ff @(posedge clk_i) begin
    if (rst_i) begin
        valid <= '0;
    end else if (fill_i) begin
        valid[index_i] <= 1'b1;
    end
end

// tag storage
always_ff @(posedge clk_i) begin
    if (fill_i) begin
        tags[index_i] <= tag_i;
    end
end

assign hit_o = valid[index_i] && (tags[index_i] == tag_i);  // same-cycle lookup

endmodule : dcache_tags

//--- hw/dcache_top.sv
`timescale 1ns/100ps

module dcache_top
    import dcache_pkg::*;
    import memop_pkg::*;
(
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            req_valid_i,
    input  dcache_req_t     req_i,
    output logic            credit_o,
    output logic            rsp_valid_o,
    output dcache_rsp_t     rsp_o,
    output logic            mem_refill_valid_o,
    output mem_refill_req_t mem_refill_o,
    input  logic            mem_line_valid_i,
    input  line_t           mem_line_i,
    output logic            mem_wt_valid_o,
    output mem_wt_t         mem_wt_o
);

// ==================================================
// decode
// ==================================================

logic          dec_valid;
dcache_req_t   dec_head;
cache_tag_t    dec_tag;
cache_index_t  dec_index;
cache_offset_t dec_offset;
logic          dec_pop;

dcache_req_decode u_decode (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .pop_i        (dec_pop),
    .head_valid_o (dec_valid),
    .head_o       (dec_head),
    .tag_o        (dec_tag),
    .index_o      (dec_index),
    .offset_o     (dec_offset),
    .credit_o     (credit_o)
);

// ==================================================
// execute
// ==================================================

logic  hit;
logic  rd;
logic  wr;
logic  fill;
logic  ld_valid;
word_t raw_word;

dcache_tags u_tags (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .index_i (dec_index),
    .tag_i   (dec_tag),
    .fill_i  (fill),
    .hit_o   (hit)
);

dcache_data u_data (
    .clk_i    (clk_i),
    .rd_i     (rd),
    .wr_i     (wr),
    .fill_i   (fill),
    .index_i  (dec_index),
    .offset_i (dec_offset),
    .size_i   (dec_head.size),
    .wdata_i  (dec_head.wdata),
    .line_i   (mem_line_i),
    .rdata_o  (raw_word)
);

dcache_ctrl u_ctrl (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .head_valid_i       (dec_valid),
    .head_i             (dec_head),
    .index_i            (dec_index),
    .hit_i              (hit),
    .mem_line_valid_i   (mem_line_valid_i),
    .pop_o              (dec_pop),
    .rd_o               (rd),
    .wr_o               (wr),
    .fill_o             (fill),
    .mem_refill_valid_o (mem_refill_valid_o),
    .mem_refill_o       (mem_refill_o),
    .mem_wt_valid_o     (mem_wt_valid_o),
    .mem_wt_o           (mem_wt_o),
    .ld_valid_o         (ld_valid)
);

// ==================================================
// result
// ==================================================

dcache_load_align u_align (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .ld_valid_i  (ld_valid),
    .raw_i       (raw_word),
    .size_i      (dec_head.size),  // head still holds the load on the read cycle
    .unsigned_i  (dec_head.is_unsigned),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o)
);

endmodule : dcache_top

//--- hw/memop_pkg.sv
package memop_pkg;

import dcache_pkg::*;

// ==================================================
// memory operations
// ==================================================

typedef enum logic [1:0] {
    BYTE,
    HALF,
    WORD
} memop_size_e;

// core side
typedef struct packed {
    logic        is_store;
    memop_size_e size;
    logic        is_unsigned;  // loads only
    addr_t       addr;
    word_t       wdata;        // stores only
} dcache_req_t;

typedef struct packed {
    word_t data;
} dcache_rsp_t;

// memory side
typedef struct packed {
    logic [DCACHE_TAG_SIZE+DCACHE_INDEX_SIZE-1:0] line_addr;
} mem_refill_req_t;

typedef struct packed {
    addr_t       addr;
    word_t       data;
    memop_size_e size;
} mem_wt_t;

endpackage : memop_pkg

//--- tb/dcache_mem_model.sv
`timescale 1ns/100ps

module dcache_mem_model
    import dcache_pkg::*;
    import memop_pkg::*;
(
    input  logic            clk_i,
    input  logic            rst_i,
    input  logic            refill_valid_i,
    input  mem_refill_req_t refill_i,
    output logic            line_valid_o,
    output line_t           line_o,
    input  logic            wt_valid_i,
    input  mem_wt_t         wt_i
);

logic [7:0]  mem [addr_t];  // only written bytes are stored
int unsigned wt_count;      // write log length
int unsigned refill_count;
int          wait_cycles;
addr_t       line_base;

// untouched bytes, mixes every address bit
function automatic logic [7:0] init_byte(addr_t a);
    return {a[3:0], a[7:4]} ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5c;
endfunction

function automatic logic [7:0] read_byte(addr_t a);
    return mem.exists(a) ? mem[a] : init_byte(a);
endfunction

initial begin
    line_valid_o = 1'b0;
    line_o       = '0;
    wt_count     = 0;
    refill_count = 0;
    wait_cycles  = -1;
end

// runs 1 ns after the edge, where DUT outputs have settled
always @(posedge clk_i) begin
    #1;
    line_valid_o = 1'b0;
    if (rst_i) begin
        wait_cycles = -1;
    end else begin
        if (wt_valid_i) begin
            for (int i = 0; i < (1 << wt_i.size); i++) begin
                mem[wt_i.addr + addr_t'(i)] = wt_i.data[i*8 +: 8];
            end
            wt_count++;
        end
        if (refill_valid_i) begin
            line_base    = {refill_i.line_addr, 4'b0000};
            wait_cycles  = 2 + refill_count % 5;  // 2 to 6 cycles
            refill_count++;
        end else if (wait_cycles > 0) begin
            wait_cycles--;
            if (wait_cycles == 0) begin
                for (int i = 0; i < DCACHE_LINE_BYTES; i++) begin
                    line_o[i*8 +: 8] = read_byte(line_base + addr_t'(i));
                end
                line_valid_o = 1'b1;
                wait_cycles  = -1;
            end
        end
    end
end

endmodule : dcache_mem_model

//--- tb/dcache_tb.sv
`timescale 1ns/100ps

module dcache_tb
    import dcache_pkg::*;
    import memop_pkg::*;
();

localparam int    CLK_PERIOD  = 100;
localparam int    NUM_REQS    = 400;
localparam int    WINDOW      = 1024;
localparam addr_t BASE        = 32'h0001_0000;
localparam int    WATCHDOG_NS = NUM_REQS * 20 * CLK_PERIOD;

logic            clk;
logic            rst;
logic            req_valid;
dcache_req_t     req;
logic            credit;
logic            rsp_valid;
dcache_rsp_t     rsp;
logic            refill_valid;
mem_refill_req_t refill;
logic            line_valid;
line_t           line;
logic            wt_valid;
mem_wt_t         wt;

logic [31:0] rng = 32'd94966;
logic [7:0]  ref_mem [WINDOW];
logic        shadow_valid [DCACHE_NUM_LINES];
cache_tag_t  shadow_tag [DCACHE_NUM_LINES];
dcache_rsp_t exp_rsp [$];
mem_wt_t     exp_wt [$];
dcache_req_t inflight [$];  // issued, not yet credited back

int credits;
int credit_pulses;
int num_stores;
int rsp_errs;
int wt_errs;
int refill_errs;
int other_errs;
logic rst_q;

dcache_top dut (
    .clk_i              (clk),
    .rst_i              (rst),
    .req_valid_i        (req_valid),
    .req_i              (req),
    .credit_o           (credit),
    .rsp_valid_o        (rsp_valid),
    .rsp_o              (rsp),
    .mem_refill_valid_o (refill_valid),
    .mem_refill_o       (refill),
    .mem_line_valid_i   (line_valid),
    .mem_line_i         (line),
    .mem_wt_valid_o     (wt_valid),
    .mem_wt_o           (wt)
);

dcache_mem_model u_mem (
    .clk_i          (clk),
    .rst_i          (rst),
    .refill_valid_i (refill_valid),
    .refill_i       (refill),
    .line_valid_o   (line_valid),
    .line_o         (line),
    .wt_valid_i     (wt_valid),
    .wt_i           (wt)
);

initial clk = 1'b0;
always #(CLK_PERIOD/2) clk = ~clk;

// ==================================================
// reference model
// ==================================================

function automatic logic [31:0] next_rand();
    rng ^= rng << 13;
    rng ^= rng >> 17;
    rng ^= rng << 5;
    return rng;
endfunction

function automatic word_t expected_load(addr_t a, memop_size_e s, logic uns);
    word_t v;
    int    n;
    v = '0;
    n = 1 << s;
    for (int i = 0; i < n; i++) v[i*8 +: 8] = ref_mem[int'(a - BASE) + i];
    if (!uns && v[n*8-1]) begin
        for (int i = n; i < 4; i++) v[i*8 +: 8] = 8'hff;
    end
    return v;
endfunction

function automatic dcache_req_t random_request();
    dcache_req_t r;
    logic [31:0] x;
    addr_t       off;
    x             = next_rand();
    r.is_store    = x[0];
    r.is_unsigned = x[1];
    r.size        = memop_size_e'(x[3:2] % 3);
    off           = addr_t'(x[13:4]) & ~addr_t'((1 << r.size) - 1);  // natural alignment
    r.addr        = BASE + off;
    r.wdata       = next_rand();
    return r;
endfunction

task automatic send_request(dcache_req_t r);
    dcache_rsp_t er;
    mem_wt_t     ew;
    if (r.is_store) begin
        for (int i = 0; i < (1 << r.size); i++) begin
            ref_mem[int'(r.addr - BASE) + i] = r.wdata[i*8 +: 8];
        end
        ew = '{addr: r.addr, data: r.wdata, size: r.size};
        exp_wt.push_back(ew);
        num_stores++;
    end else begin
        er = '{data: expected_load(r.addr, r.size, r.is_unsigned)};
        exp_rsp.push_back(er);
    end
    inflight.push_back(r);
    credits--;
    req       = r;
    req_valid = 1'b1;
endtask

// ==================================================
// checks
// ==================================================

task automatic check_rsp(dcache_rsp_t got, dcache_rsp_t exp);
    if (got !== exp) begin
        rsp_errs++;
        $display("mismatch rsp_o: got %h expected %h", got, exp);
    end
endtask

task automatic check_wt(mem_wt_t got, mem_wt_t exp);
    if (got !== exp) begin
        wt_errs++;
        $display("mismatch mem_wt_o: got %h expected %h", got, exp);
    end
endtask

task automatic check_refill(mem_refill_req_t got, mem_refill_req_t exp);
    if (got !== exp) begin
        refill_errs++;
        $display("mismatch mem_refill_o: got %h expected %h", got, exp);
    end
endtask

task automatic report_error(string what);
    other_errs++;
    $display("error: %s at %0t", what, $time);
endtask

// monitor at the falling edge, away from drive and update points
always @(negedge clk) begin
    dcache_req_t     h;
    mem_refill_req_t er;
    if ((rst || rst_q) && (credit !== 1'b0 || rsp_valid !== 1'b0
            || refill_valid !== 1'b0 || wt_valid !== 1'b0)) begin
        report_error("outputs active during or right after reset");
    end
    rst_q = rst;
    if (!rst) begin
        if (wt_valid) begin
            if (exp_wt.size() == 0) report_error("write-through with no store outstanding");
            else check_wt(wt, exp_wt.pop_front());
        end
        if (refill_valid) begin
            if (inflight.size() == 0 || inflight[0].is_store) begin
                report_error("refill with no load at the queue head");
            end else begin
                h  = inflight[0];
                er = '{line_addr: h.addr[31:4]};
                check_refill(refill, er);
                if (shadow_valid[h.addr[7:4]] && shadow_tag[h.addr[7:4]] == h.addr[31:8]) begin
                    report_error("refill for a line that is already present");
                end
                shadow_valid[h.addr[7:4]] = 1'b1;
                shadow_tag[h.addr[7:4]]   = h.addr[31:8];
            end
        end
        if (rsp_valid) begin
            if (exp_rsp.size() == 0) report_error("load response with no load outstanding");
            else check_rsp(rsp, exp_rsp.pop_front());
        end
        if (credit) begin
            credits++;
            credit_pulses++;
            if (inflight.size() == 0) begin
                report_error("credit returned with nothing in flight");
            end else begin
                h = inflight.pop_front();
                if (!h.is_store && !(shadow_valid[h.addr[7:4]]
                        && shadow_tag[h.addr[7:4]] == h.addr[31:8])) begin
                    report_error("load finished without refilling its missing line");
                end
            end
        end
    end
end

// ==================================================
// stimulus
// ==================================================

initial begin
    int sent;
    rst       = 1'b1;
    rst_q     = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    credits   = DCACHE_CREDITS;
    sent      = 0;
    for (int i = 0; i < WINDOW; i++) ref_mem[i] = u_mem.init_byte(BASE + addr_t'(i));
    for (int i = 0; i < DCACHE_NUM_LINES; i++) begin
        shadow_valid[i] = 1'b0;
        shadow_tag[i]   = '0;
    end
    repeat (5) @(posedge clk);
    #1 rst = 1'b0;

    while (sent < NUM_REQS) begin
        @(posedge clk);
        #1 req_valid = 1'b0;
        if (credits > 0 && next_rand() % 4 != 0) begin  // some idle cycles
            send_request(random_request());
            sent++;
        end
    end
    @(posedge clk);
    #1 req_valid = 1'b0;

    while (credits != DCACHE_CREDITS) @(posedge clk);
    repeat (4) @(posedge clk);  // catch stray outputs

    if (credit_pulses != NUM_REQS) report_error("credit pulses differ from request count");
    if (exp_rsp.size() != 0) report_error("load responses missing at end of run");
    if (exp_wt.size() != 0) report_error("write-throughs missing at end of run");
    if (u_mem.wt_count != num_stores) report_error("memory saw a wrong number of writes");

    $display("errors: rsp %0d, write-through %0d, refill %0d, other %0d",
             rsp_errs, wt_errs, refill_errs, other_errs);
    if (rsp_errs + wt_errs + refill_errs + other_errs == 0) begin
        $display("TB PASSED");
    end else begin
        $display("TB FAILED");
    end
    $finish;
end

initial begin
    #(WATCHDOG_NS);
    $display("error: watchdog timeout, requests or credits stalled");
    $display("TB FAILED");
    $finish;
end

endmodule : dcache_tb
